// File: tb.f
source/emesh_pkg.sv
source/emem_wr_channel.sv
source/emem_rd_channel.sv
source/emem_core.sv
source/emesh_mem_top.sv
tb/emesh_mem_sva.sv
tb/tb_emesh_mem.sv

// File: Makefile
TOP := tb_emesh_mem

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only -Wall source/emesh_pkg.sv source/emem_wr_channel.sv \
		source/emem_rd_channel.sv source/emem_core.sv source/emesh_mem_top.sv \
		--top-module emesh_mem_top

clean:
	rm -rf obj_dir

// File: tb/tb_emesh_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_emesh_mem;

   import emesh_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int WAIT_LIMIT  = 20;                 // Cycles per handshake
   localparam int TEST_CYCLES = 10 + 20 + 80 + 40 + 200 + 40; // Per test in run order
   localparam int MARGIN      = 100;

   logic          clk;
   logic          nreset;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;

   logic [DW-1:0] model [MEM_DEPTH];                // Reference memory
   logic [31:0]   lcg_state;
   int            errors;
   int            checks;

   emesh_mem_top u_dut (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //####################################################################
   //# Stimulus and reference helpers
   //####################################################################
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic emesh_packet_t make_req(input logic wr, input datamode_t dm,
         input logic [4:0] ctrl, input logic [AW-1:0] dst, input logic [DW-1:0] data,
         input logic [AW-1:0] src);
      emesh_packet_t p;
      p.write    = wr;
      p.datamode = dm;
      p.ctrlmode = ctrl;
      p.dstaddr  = dst;
      p.data     = data;
      p.srcaddr  = src;
      return p;
   endfunction

   // First byte lane and byte count of a transfer
   function automatic void lane_span(input logic [AW-1:0] addr, input datamode_t dm,
                                     output int first, output int nbytes);
      first  = 0;
      nbytes = 4;                                   // Word and double
      if (dm == DM_BYTE) begin
         first  = int'(addr[1:0]);
         nbytes = 1;
      end else if (dm == DM_HALF) begin
         first  = addr[1] ? 2 : 0;                  // Bit 0 ignored
         nbytes = 2;
      end
   endfunction

   function automatic void model_write(input logic [AW-1:0] addr, input datamode_t dm,
                                       input logic [DW-1:0] data);
      int first;
      int nbytes;
      lane_span(addr, dm, first, nbytes);
      for (int b = 0; b < nbytes; b++)
         model[addr[MEM_AW+1:2]][8*(first+b) +: 8] = data[8*b +: 8]; // Low bytes to lanes
   endfunction

   function automatic emesh_packet_t expect_resp(input emesh_packet_t req);
      emesh_packet_t exp;
      logic [DW-1:0] word;
      int            first;
      int            nbytes;
      lane_span(req.dstaddr, req.datamode, first, nbytes);
      word        = model[req.dstaddr[MEM_AW+1:2]];
      exp         = req;                            // Modes echoed
      exp.write   = 1'b0;
      exp.dstaddr = req.srcaddr;                    // Addresses swap
      exp.srcaddr = req.dstaddr;
      exp.data    = '0;                             // Zero-extended lane
      for (int b = 0; b < nbytes; b++)
         exp.data[8*b +: 8] = word[8*(first+b) +: 8];
      return exp;
   endfunction

   //####################################################################
   //# Compare tasks
   //####################################################################
   task automatic check_packet(input string name, input emesh_packet_t got,
                               input emesh_packet_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, exp);
      end
   endtask

   //####################################################################
   //# Bus tasks
   //####################################################################
   task automatic send_req(input emesh_packet_t pkt);
      int waited;
      waited = 0;
      @(negedge clk);
      access_in = 1'b1;
      packet_in = pkt;
      while (wait_out && waited < WAIT_LIMIT) begin // wait_out is registered
         @(negedge clk);
         waited++;
      end
      if (wait_out) begin
         errors++;
         $display("Request to address %h was never accepted", pkt.dstaddr);
      end
      @(negedge clk);                               // Taken on the edge just passed
      access_in = 1'b0;
   endtask

   task automatic get_resp(output emesh_packet_t pkt);
      int waited;
      waited = 0;
      pkt    = '0;
      do begin
         @(negedge clk);
         waited++;
      end while (!access_out && waited < WAIT_LIMIT);
      if (access_out)
         pkt = packet_out;
      else begin
         errors++;
         $display("No read response arrived within %0d cycles", WAIT_LIMIT);
      end
   endtask

   task automatic do_write(input datamode_t dm, input logic [AW-1:0] addr,
                           input logic [DW-1:0] data);
      send_req(make_req(1'b1, dm, 5'h00, addr, data, 32'h0));
      model_write(addr, dm, data);
   endtask

   task automatic read_check(input datamode_t dm, input logic [AW-1:0] addr);
      emesh_packet_t req;
      emesh_packet_t resp;
      logic [31:0]   rnd;
      rnd = lcg_next();
      req = make_req(1'b0, dm, rnd[4:0], addr, 32'h0, rnd); // Random ctrl and return
      send_req(req);
      get_resp(resp);
      check_packet("packet_out", resp, expect_resp(req));
   endtask

   //####################################################################
   //# Directed tests
   //####################################################################
   task automatic reset_values();
      check_level("access_out", access_out, 1'b0);
      check_level("wait_out", wait_out, 1'b0);
      check_packet("packet_out", packet_out, '0);
   endtask

   task automatic word_roundtrip();
      do_write(DM_WORD, 32'h0000_0040, 32'hdead_beef);
      read_check(DM_WORD, 32'h0000_0040);
   endtask

   task automatic lane_merge();
      do_write(DM_WORD, 32'h0000_0100, 32'h1122_3344);
      do_write(DM_BYTE, 32'h0000_0103, 32'h0000_005c);
      do_write(DM_HALF, 32'h0000_0100, 32'h0000_beef); // Lanes 0 and 1
      do_write(DM_BYTE, 32'h0000_0101, 32'h0000_00a5);
      for (int i = 0; i < 4; i++)
         read_check(DM_BYTE, 32'h0000_0100 + i);
      read_check(DM_HALF, 32'h0000_0100);
      read_check(DM_HALF, 32'h0000_0102);
      read_check(DM_WORD, 32'h0000_0100);
      read_check(DM_DOUBLE, 32'h0000_0100);
   endtask

   task automatic backpressure_order();
      emesh_packet_t reqs [$];
      emesh_packet_t held;
      emesh_packet_t resp;
      emesh_packet_t req;
      logic [31:0]   rnd;
      int            sent;
      sent = 0;
      @(negedge clk);
      wait_in = 1'b1;
      while (!wait_out && sent < 4) begin
         rnd = lcg_next();
         req = make_req(1'b0, DM_BYTE, rnd[4:0], 32'h0000_0100 + sent, 32'h0, rnd);
         send_req(req);
         reqs.push_back(req);
         sent++;
         if (sent == 1) begin
            get_resp(held);                         // Stays in the response reg
            check_packet("packet_out", held, expect_resp(req));
         end else
            check_packet("packet_out", packet_out, expect_resp(reqs[0]));
      end
      check_level("wait_out", wait_out, 1'b1);
      wait_in = 1'b0;                               // Still at a falling edge
      void'(reqs.pop_front());
      while (reqs.size() > 0) begin
         get_resp(resp);
         check_packet("packet_out", resp, expect_resp(reqs.pop_front()));
      end
      @(negedge clk);
      check_level("access_out", access_out, 1'b0);  // No duplicate
   endtask

   task automatic random_traffic();
      logic [AW-1:0] pool [8];
      logic [AW-1:0] addr;
      logic [31:0]   rnd;
      logic [31:0]   high;
      datamode_t     dm;
      for (int i = 0; i < 8; i++) begin
         rnd     = lcg_next();
         pool[i] = {22'h0, rnd[MEM_AW+1:2], 2'b00};
         do_write(DM_WORD, pool[i], lcg_next());    // Every byte defined
      end
      for (int i = 0; i < 20; i++) begin
         rnd  = lcg_next();
         high = lcg_next();
         dm   = datamode_t'(rnd[5:4]);
         addr = pool[rnd[2:0]];
         addr[AW-1:MEM_AW+2] = high[AW-1:MEM_AW+2]; // Upper bits alias
         if (dm == DM_BYTE)
            addr[1:0] = rnd[7:6];
         else if (dm == DM_HALF)
            addr[1:0] = {rnd[7], 1'b0};
         if (rnd[8])
            do_write(dm, addr, lcg_next());
         else
            read_check(dm, addr);
      end
   endtask

   task automatic write_during_reads();
      emesh_packet_t r1;
      emesh_packet_t r2;
      emesh_packet_t resp;
      r1 = make_req(1'b0, DM_WORD, 5'h03, 32'h0000_0040, 32'h0, 32'haaaa_0010);
      r2 = make_req(1'b0, DM_WORD, 5'h1c, 32'h0000_0100, 32'h0, 32'hbbbb_0020);
      @(negedge clk);
      wait_in = 1'b1;
      send_req(r1);
      send_req(r2);                                 // Waits in the read queue
      get_resp(resp);
      check_packet("packet_out", resp, expect_resp(r1));
      do_write(DM_WORD, 32'h0000_0200, 32'hcafe_f00d);
      check_level("wait_out", wait_out, 1'b0);
      wait_in = 1'b0;
      get_resp(resp);
      check_packet("packet_out", resp, expect_resp(r2));
      read_check(DM_WORD, 32'h0000_0200);
   endtask

   //####################################################################
   //# Run and watchdog
   //####################################################################
   initial begin
      nreset    = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      errors    = 0;
      checks    = 0;
      lcg_state = 32'hb27f99cc;
      #10;
      nreset = 1'b0;                                // Clean falling edge
      repeat (4) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      reset_values();
      word_roundtrip();
      lane_merge();
      backpressure_order();
      random_traffic();
      write_during_reads();
      $display("Done: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   initial begin
      #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
      $display("Timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/emesh_mem_sva.sv
`timescale 1ns/10ps
`default_nettype none

module emesh_mem_sva (
   input logic                     clk,
   input logic                     nreset,
   input logic                     wait_in,
   input logic                     wait_out,
   input logic                     access_out,
   input emesh_pkg::emesh_packet_t packet_out
);

   // Both output levels quiet while in reset
   a_reset_quiet: assert property (@(posedge clk)
      !nreset |-> (!access_out && !wait_out))
      else $error("access_out or wait_out high during reset");

   // Stalled response must not move
   a_hold_stable: assert property (@(posedge clk) disable iff (!nreset)
      (access_out && wait_in) |=> $stable(packet_out))
      else $error("packet_out changed while stalled by wait_in");

   a_wait_known: assert property (@(posedge clk) disable iff (!nreset)
      !$isunknown(wait_out))
      else $error("wait_out is unknown after reset");

endmodule

bind emesh_mem_top emesh_mem_sva u_sva (
   .clk        (clk),
   .nreset     (nreset),
   .wait_in    (wait_in),
   .wait_out   (wait_out),
   .access_out (access_out),
   .packet_out (packet_out)
);

`default_nettype wire

// File: source/emesh_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module emesh_mem_top (
   input  logic                    clk,
   input  logic                    nreset,
   input  logic                    access_in,
   input  emesh_pkg::emesh_packet_t packet_in,
   output logic                    wait_out,
   output logic                    access_out,
   output emesh_pkg::emesh_packet_t packet_out,
   input  logic                    wait_in
);

   import emesh_pkg::*;

   logic      req_take;                             // Request accepted this edge
   logic      wr_valid;
   logic      wr_full;
   logic      wr_pop;
   mem_wr_t   wr_head;
   logic      rd_valid;
   logic      rd_full;
   logic      rd_pop;
   mem_rd_t   rd_head;

   // Shared wait blocks both channels
   assign req_take = access_in & ~wait_out;

   //####################################################################
   //# Channels
   //####################################################################
   emem_wr_channel u_wr (
      .clk       (clk),
      .nreset    (nreset),
      .access_in (req_take),
      .packet_in (packet_in),
      .wr_pop    (wr_pop),
      .wr_valid  (wr_valid),
      .wr_head   (wr_head),
      .wr_full   (wr_full)
   );

   emem_rd_channel u_rd (
      .clk       (clk),
      .nreset    (nreset),
      .access_in (req_take),
      .packet_in (packet_in),
      .rd_pop    (rd_pop),
      .rd_valid  (rd_valid),
      .rd_head   (rd_head),
      .rd_full   (rd_full)
   );

   //####################################################################
   //# Memory core
   //####################################################################
   emem_core u_core (
      .clk        (clk),
      .nreset     (nreset),
      .wr_valid   (wr_valid),
      .wr_head    (wr_head),
      .wr_full    (wr_full),
      .rd_valid   (rd_valid),
      .rd_head    (rd_head),
      .rd_full    (rd_full),
      .wait_in    (wait_in),
      .wr_pop     (wr_pop),
      .rd_pop     (rd_pop),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

`default_nettype wire

// File: source/emem_core.sv
`timescale 1ns/10ps
`default_nettype none

module emem_core (
   input  logic                    clk,
   input  logic                    nreset,
   input  logic                    wr_valid,
   input  emesh_pkg::mem_wr_t      wr_head,
   input  logic                    wr_full,
   input  logic                    rd_valid,
   input  emesh_pkg::mem_rd_t      rd_head,
   input  logic                    rd_full,
   input  logic                    wait_in,
   output logic                    wr_pop,
   output logic                    rd_pop,
   output logic                    wait_out,
   output logic                    access_out,
   output emesh_pkg::emesh_packet_t packet_out
);

   import emesh_pkg::*;

   logic [DW-1:0]     mem [MEM_DEPTH];              // Single-port array
   logic [MEM_AW-1:0] mem_addr;                     // Shared port address
   logic [DW-1:0]     rd_word;                      // Word at mem_addr
   logic [DW-1:0]     rd_shift;                     // Lane moved to bit 0
   logic [DW-1:0]     rd_data;                      // Zero-extended result
   logic              resp_free;                    // Response reg can load
   emesh_packet_t     resp_pkt;

   //####################################################################
   //# Arbitration
   //####################################################################
   // Writes always win, reads wait for an idle write queue
   assign resp_free = ~access_out | ~wait_in;       // Empty or being consumed
   assign wr_pop    = wr_valid;
   assign rd_pop    = ~wr_valid & rd_valid & resp_free;

   assign mem_addr  = wr_valid ? wr_head.index : rd_head.index;

   // Either queue full holds off the sender
   assign wait_out  = wr_full | rd_full;

   //####################################################################
   //# Memory
   //####################################################################
   always_ff @(posedge clk) begin
      for (int i = 0; i < SW; i++) begin
         if (wr_pop && wr_head.strb[i])
            mem[mem_addr][8*i +: 8] <= wr_head.data[8*i +: 8]; // Masked byte
      end
   end

   assign rd_word = mem[mem_addr];                  // Async read

   //####################################################################
   //# Response
   //####################################################################
   assign rd_shift = rd_word >> {rd_head.lane, 3'b000};

   always_comb begin
      case (rd_head.datamode)
         DM_BYTE: rd_data = {24'b0, rd_shift[7:0]};
         DM_HALF: rd_data = {16'b0, rd_word[{rd_head.lane[1], 4'b0000} +: 16]};
         default: rd_data = rd_word;                // Word and double
      endcase
   end

   always_comb begin
      resp_pkt.write    = 1'b0;                     // Read response
      resp_pkt.datamode = rd_head.datamode;         // Echoed
      resp_pkt.ctrlmode = rd_head.ctrlmode;
      resp_pkt.dstaddr  = rd_head.ret_addr;         // Back to requester
      resp_pkt.data     = rd_data;
      resp_pkt.srcaddr  = rd_head.echo_addr;
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         access_out <= 1'b0;
         packet_out <= emesh_packet_t'({PW{1'b0}});
      end else if (rd_pop) begin
         access_out <= 1'b1;                        // New response
         packet_out <= resp_pkt;
      end else if (!wait_in) begin
         access_out <= 1'b0;                        // Consumed, nothing new
      end
   end

   // packet_out only moves on rd_pop, so it holds under wait_in

endmodule

`default_nettype wire

// File: source/emem_rd_channel.sv
`timescale 1ns/10ps
`default_nettype none

module emem_rd_channel (
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   access_in,
   input  emesh_pkg::emesh_packet_t packet_in,
   input  logic                   rd_pop,
   output logic                   rd_valid,
   output emesh_pkg::mem_rd_t     rd_head,
   output logic                   rd_full
);

   import emesh_pkg::*;

   mem_rd_t           q_mem [QDEPTH];               // Entry storage
   logic [QPW-1:0]    wr_ptr;                       // Next free slot
   logic [QPW-1:0]    rd_ptr;                       // Head slot
   logic [QPW:0]      count;                        // Entries held
   logic              push;
   logic              pop;
   mem_rd_t           entry;                        // Prepared request

   //####################################################################
   //# Response header prep
   //####################################################################
   always_comb begin
      entry.index     = packet_in.dstaddr[MEM_AW+1:2];
      entry.lane      = packet_in.dstaddr[1:0];     // Byte offset for extract
      entry.datamode  = packet_in.datamode;
      entry.ctrlmode  = packet_in.ctrlmode;
      entry.ret_addr  = packet_in.srcaddr;          // Response goes back here
      entry.echo_addr = packet_in.dstaddr;          // Shown as response source
   end

   // Half reads only look at bit 1 of the lane, core drops bit 0

   //####################################################################
   //# Queue
   //####################################################################
   assign push = access_in & ~packet_in.write & ~rd_full; // Reads only
   assign pop  = rd_pop & rd_valid;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;                // Wraps at QDEPTH
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         q_mem[wr_ptr] <= entry;
   end

   assign rd_valid = (count != '0);
   assign rd_full  = (count == QDEPTH[QPW:0]);      // Feeds wait_out
   assign rd_head  = q_mem[rd_ptr];

endmodule

`default_nettype wire

// File: source/emem_wr_channel.sv
`timescale 1ns/10ps
`default_nettype none

module emem_wr_channel (
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   access_in,
   input  emesh_pkg::emesh_packet_t packet_in,
   input  logic                   wr_pop,
   output logic                   wr_valid,
   output emesh_pkg::mem_wr_t     wr_head,
   output logic                   wr_full
);

   import emesh_pkg::*;

   mem_wr_t           q_mem [QDEPTH];               // Entry storage
   logic [QPW-1:0]    wr_ptr;                       // Next free slot
   logic [QPW-1:0]    rd_ptr;                       // Head slot
   logic [QPW:0]      count;                        // Entries held
   logic              push;
   logic              pop;
   mem_wr_t           entry;                        // Converted request

   //####################################################################
   //# Request conversion
   //####################################################################
   always_comb begin
      entry.index = packet_in.dstaddr[MEM_AW+1:2];  // Upper bits alias
      case (packet_in.datamode)
         DM_BYTE: begin
            entry.strb = 4'b0001 << packet_in.dstaddr[1:0];
            entry.data = packet_in.data << {packet_in.dstaddr[1:0], 3'b000};
         end
         DM_HALF: begin
            entry.strb = 4'b0011 << {packet_in.dstaddr[1], 1'b0}; // Bit 0 ignored
            entry.data = packet_in.data << {packet_in.dstaddr[1], 4'b0000};
         end
         default: begin                             // Word and double
            entry.strb = 4'b1111;
            entry.data = packet_in.data;
         end
      endcase
   end

   //####################################################################
   //# Queue
   //####################################################################
   assign push = access_in & packet_in.write & ~wr_full; // Writes only
   assign pop  = wr_pop & wr_valid;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;                // Wraps at QDEPTH
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         q_mem[wr_ptr] <= entry;
   end

   assign wr_valid = (count != '0);
   assign wr_full  = (count == QDEPTH[QPW:0]);      // From registered count
   assign wr_head  = q_mem[rd_ptr];

endmodule

`default_nettype wire

// File: source/emesh_pkg.sv
`default_nettype none

package emesh_pkg;

   //####################################################################
   //# Sizes
   //####################################################################
   localparam int unsigned AW        = 32;            // Address width
   localparam int unsigned DW        = 32;            // Data width
   localparam int unsigned PW        = 104;           // Packet width
   localparam int unsigned MEM_AW    = 8;             // Word index bits
   localparam int unsigned MEM_DEPTH = 1 << MEM_AW;   // 256 words
   localparam int unsigned SW        = DW / 8;        // Byte strobes per word
   localparam int unsigned QDEPTH    = 2;             // Channel queue depth
   localparam int unsigned QPW       = $clog2(QDEPTH); // Queue pointer bits

   //####################################################################
   //# Transfer size
   //####################################################################
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,                              // 8 bits
      DM_HALF   = 2'b01,                              // 16 bits
      DM_WORD   = 2'b10,                              // 32 bits
      DM_DOUBLE = 2'b11                               // Handled as word here
   } datamode_t;

   //####################################################################
   //# Emesh packet, msb first
   //####################################################################
   typedef struct packed {
      logic              write;                       // 1 = write, 0 = read
      datamode_t         datamode;
      logic [4:0]        ctrlmode;
      logic [AW-1:0]     dstaddr;
      logic [DW-1:0]     data;
      logic [AW-1:0]     srcaddr;                     // Return address for reads
   } emesh_packet_t;

   // Write as the memory wants it
   typedef struct packed {
      logic [MEM_AW-1:0] index;                       // Word index
      logic [DW-1:0]     data;                        // Already in its byte lanes
      logic [SW-1:0]     strb;                        // One bit per byte
   } mem_wr_t;

   // Read plus what the response needs
   typedef struct packed {
      logic [MEM_AW-1:0] index;                       // Word index
      logic [1:0]        lane;                        // Byte offset in word
      datamode_t         datamode;
      logic [4:0]        ctrlmode;
      logic [AW-1:0]     ret_addr;                    // Request srcaddr
      logic [AW-1:0]     echo_addr;                   // Request dstaddr
   } mem_rd_t;

endpackage

`default_nettype wire
